/* logic/sobel_defines.svh */
/* sobel edge detector parameters
   frame geometry, pixel and gradient widths, bus address width */

`ifndef SOBEL_DEFINES_SVH
`define SOBEL_DEFINES_SVH

// frame geometry, any size of at least 3x3
`define IMG_W 16 // pixels per row
`define IMG_H 8  // rows per frame

// data widths
`define PIX_W 10  // grayscale pixel
`define OUT_W 16  // result word on the write port
`define GRAD_W 14 // sector sums, differences and magnitude

// wishbone word address, must cover IMG_W*IMG_H
`define ADDR_W 18

`endif

/* logic/sobel_pkg.sv */
/* sobel edge detector shared types
   pixel and gradient values plus the fetch and row buffer FSM states */

`include "sobel_defines.svh"

package sobel_pkg;

	// one grayscale (or binarized) pixel
	typedef logic [`PIX_W-1:0] pixel_t;

	// unsigned gradient magnitude, wide enough for 4*max pixel plus 1/8
	typedef logic [`GRAD_W-1:0] grad_t;

	// wishbone read master in pixel_fetch
	typedef enum logic [1:0]
	{
		FETCH_IDLE, // waiting for start or frame finished
		FETCH_READ, // cyc/stb up, waiting on ack
		FETCH_PUSH  // pixel held until the row buffer takes it
	} fetch_state_t;

	// row buffer phases, load a row then stream the columns
	typedef enum logic
	{
		BUF_FILL,  // taking pixels into the oldest row memory
		BUF_DRAIN  // emitting IMG_W three-pixel columns
	} buf_state_t;

endpackage

/* logic/pixel_fetch.sv */
/* pixel fetch
   wishbone read master that walks the frame in raster order and
   passes each pixel on as black or white against a threshold */

`timescale 1ns/1ns
`include "sobel_defines.svh"

module pixel_fetch
	import sobel_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,         // one cycle, begins a frame
	input  pixel_t             pix_threshold, // below this the pixel goes black
	// wishbone read port
	output logic               rd_cyc,
	output logic               rd_stb,
	output logic [`ADDR_W-1:0] rd_adr,
	input  pixel_t             rd_dat_i,
	input  logic               rd_ack,
	// pixel stream to the row buffer
	output logic               pix_valid,
	output pixel_t             pix_data,
	input  logic               pix_ready
);

	// address of the bottom right pixel
	localparam logic [`ADDR_W-1:0] LAST_ADR = `ADDR_W'(`IMG_W * `IMG_H - 1);

	fetch_state_t state;
	pixel_t       pix_bin; // returned word after thresholding

	// black or white only, same rule as the sdram loader
	assign pix_bin = (rd_dat_i < pix_threshold) ? '0 : '1;

	// bus strobes follow the read state directly, so stb drops the cycle after ack
	assign rd_cyc    = (state == FETCH_READ);
	assign rd_stb    = (state == FETCH_READ);
	assign pix_valid = (state == FETCH_PUSH);

	////////////////////////////////////////////////////////////////////////////
	// read sequencer
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state  <= FETCH_IDLE;
			rd_adr <= '0;
		end
		else
		begin
			case (state)
				FETCH_IDLE:
				begin
					if (start)
					begin
						rd_adr <= '0; // frame starts top left
						state  <= FETCH_READ;
					end
				end
				FETCH_READ:
				begin
					if (rd_ack)
						state <= FETCH_PUSH; // one pixel per ack
				end
				FETCH_PUSH:
				begin
					if (pix_ready)
					begin
						if (rd_adr == LAST_ADR)
							state <= FETCH_IDLE; // whole frame sent
						else
						begin
							rd_adr <= rd_adr + 1'b1;
							state  <= FETCH_READ;
						end
					end
				end
				default: state <= FETCH_IDLE;
			endcase
		end
	end

	// pixel register, captured on ack and held through the push phase
	always_ff @(posedge clk)
	begin
		if (state == FETCH_READ && rd_ack)
			pix_data <= pix_bin;
	end

endmodule

/* logic/line_buffer.sv */
/* line buffer
   three rotating row memories, filled one pixel at a time and drained
   as top/middle/bottom columns, oldest row on top */

`timescale 1ns/1ns
`include "sobel_defines.svh"

module line_buffer
	import sobel_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   start,
	// pixels from the fetch block
	input  logic   pix_valid,
	input  pixel_t pix_data,
	output logic   pix_ready,
	// columns to the core
	output logic   col_valid,
	output pixel_t col_top,
	output pixel_t col_mid,
	output pixel_t col_bot,
	input  logic   col_ready
);

	localparam int X_W = $clog2(`IMG_W);
	localparam int R_W = $clog2(`IMG_H + 1);

	localparam logic [X_W-1:0] X_LAST = X_W'(`IMG_W - 1);
	localparam logic [R_W-1:0] R_ALL  = R_W'(`IMG_H);

	pixel_t row_mem [3][`IMG_W]; // three row rams

	buf_state_t     state;
	logic           active;  // frame in progress
	logic [1:0]     rot;     // memory with the oldest row, also the next one written
	logic [1:0]     rot_p1;
	logic [1:0]     rot_p2;
	logic [X_W-1:0] wx;      // write column during fill
	logic [X_W-1:0] rx;      // next read column during drain
	logic           rx_done; // last column address issued
	logic [X_W-1:0] raddr;   // registered read address, shared by all three rams
	logic [R_W-1:0] row_cnt; // rows stored so far this frame
	logic           push;
	logic           pop;
	logic           issue;

	assign rot_p1 = (rot == 2'd2) ? 2'd0 : rot + 2'd1;
	assign rot_p2 = (rot == 2'd0) ? 2'd2 : rot - 2'd1;

	assign pix_ready = active && (state == BUF_FILL); // low while draining
	assign push      = pix_valid && pix_ready;
	assign pop       = col_valid && col_ready;
	// next address goes out when the output slot is empty or being emptied
	assign issue = active && (state == BUF_DRAIN) && !rx_done && (!col_valid || col_ready);

	// rows leave oldest to newest, so the core never sees the rotation
	assign col_top = row_mem[rot][raddr];
	assign col_mid = row_mem[rot_p1][raddr];
	assign col_bot = row_mem[rot_p2][raddr];

	////////////////////////////////////////////////////////////////////////////
	// ram write and read address
	always_ff @(posedge clk)
	begin
		if (push)
			row_mem[rot][wx] <= pix_data; // written the cycle it is accepted
		if (issue)
			raddr <= rx; // data shows one cycle later
	end

	////////////////////////////////////////////////////////////////////////////
	// fill / drain sequencing
	always_ff @(posedge clk)
	begin
		if (!rst_n || start)
		begin
			state     <= BUF_FILL;
			active    <= start; // reset leaves it idle
			rot       <= 2'd0;
			wx        <= '0;
			rx        <= '0;
			rx_done   <= 1'b0;
			row_cnt   <= '0;
			col_valid <= 1'b0;
		end
		else
		begin
			if (issue)
				col_valid <= 1'b1;
			else if (pop)
				col_valid <= 1'b0;

			case (state)
				BUF_FILL:
				begin
					if (push)
					begin
						if (wx == X_LAST)
						begin
							wx      <= '0;
							rot     <= rot_p1; // newest row now sits behind the pointer
							row_cnt <= row_cnt + 1'b1;
							if (row_cnt >= R_W'(2))
								state <= BUF_DRAIN; // three rows present
						end
						else
							wx <= wx + 1'b1;
					end
				end
				BUF_DRAIN:
				begin
					if (issue)
					begin
						if (rx == X_LAST)
						begin
							rx      <= '0;
							rx_done <= 1'b1;
						end
						else
							rx <= rx + 1'b1;
					end
					// only the last column can be pending once rx_done is set
					if (pop && rx_done)
					begin
						rx_done <= 1'b0;
						state   <= BUF_FILL;
						if (row_cnt == R_ALL)
							active <= 1'b0; // bottom row drained, frame over
					end
				end
				default: state <= BUF_FILL;
			endcase
		end
	end

endmodule

/* logic/sobel_core.sv */
/* sobel core
   3x3 window, four-direction gradient pipeline, edge decision and the
   wishbone write master for the result words */

`timescale 1ns/1ns
`include "sobel_defines.svh"

module sobel_core
	import sobel_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic [6:0]         edge_threshold, // compared as edge_threshold*32
	input  logic               show_original,  // write thresholded centre instead
	// columns from the line buffer
	input  logic               col_valid,
	input  pixel_t             col_top,
	input  pixel_t             col_mid,
	input  pixel_t             col_bot,
	output logic               col_ready,
	// wishbone write port
	output logic               wr_cyc,
	output logic               wr_stb,
	output logic               wr_we,
	output logic [`ADDR_W-1:0] wr_adr,
	output logic [`OUT_W-1:0]  wr_dat_o,
	input  logic               wr_ack,
	// frame status
	output logic               busy,
	output logic               done
);

	localparam int X_W = $clog2(`IMG_W);
	localparam logic [X_W-1:0]     X_LAST   = X_W'(`IMG_W - 1);
	// centre (IMG_W-2, IMG_H-2) is the last interior pixel
	localparam logic [`ADDR_W-1:0] LAST_ADR = `ADDR_W'((`IMG_H - 2) * `IMG_W + `IMG_W - 2);

	// weighted sector sum p + 2q + r
	function automatic grad_t wsum(input pixel_t p, input pixel_t q, input pixel_t r);
		return grad_t'(p) + (grad_t'(q) << 1) + grad_t'(r);
	endfunction

	function automatic grad_t absdiff(input grad_t x, input grad_t y);
		return (x > y) ? x - y : y - x;
	endfunction

	pixel_t a1, a2, a3, b1, b2, b3, c1, c2, c3; // window, a = top row, 3 = newest column
	logic [X_W-1:0]     cx;       // column index within the current row
	logic [`ADDR_W-1:0] row_base; // y*IMG_W of the window centre row
	logic               take;
	logic               adv;      // pipeline moves, nothing waiting on the bus

	logic               s1_valid, s2_valid, s3_valid, s4_valid;
	logic [`ADDR_W-1:0] s1_adr, s2_adr, s3_adr, s4_adr;
	pixel_t             s2_pix, s3_pix;       // centre pixel
	grad_t              sec1, sec2, sec3, sec4, sec5, sec6, sec7, sec8;
	grad_t              d_ne_sw, d_n_s, d_e_w, d_nw_se;
	logic [`OUT_W-1:0]  s4_dat;

	grad_t edge1, prep1, edge2, prep2; // pairwise winners and their perpendiculars
	grad_t edge_max, edge_prep;
	grad_t magnitude;
	grad_t thresh;

	assign adv       = !wr_stb; // hold everything from request through the ack cycle
	assign col_ready = busy && adv;
	assign take      = col_valid && col_ready;
	assign wr_cyc    = wr_stb;
	assign wr_we     = wr_stb; // write only port

	assign thresh = grad_t'({edge_threshold, 5'b00000});

	// stage 4 selection, strongest direction plus 1/8 of the one at right angles
	always_comb
	begin
		edge1 = (d_ne_sw > d_n_s) ? d_ne_sw : d_n_s;
		prep1 = (d_ne_sw > d_n_s) ? d_nw_se : d_e_w;
		edge2 = (d_e_w > d_nw_se) ? d_e_w : d_nw_se;
		prep2 = (d_e_w > d_nw_se) ? d_n_s : d_ne_sw;
		edge_max  = (edge1 > edge2) ? edge1 : edge2;
		edge_prep = (edge1 > edge2) ? prep1 : prep2;
		magnitude = edge_max + (edge_prep >> 3);
	end

	////////////////////////////////////////////////////////////////////////////
	// control: valids, position, bus handshake, status
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			busy     <= 1'b0;
			done     <= 1'b0;
			wr_stb   <= 1'b0;
			cx       <= '0;
			row_base <= `ADDR_W'(`IMG_W);
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			s4_valid <= 1'b0;
		end
		else if (start)
		begin
			busy     <= 1'b1;
			done     <= 1'b0;
			wr_stb   <= 1'b0;
			cx       <= '0;
			row_base <= `ADDR_W'(`IMG_W); // first centre row is y = 1
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			s4_valid <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (adv)
			begin
				s1_valid <= take && (cx >= X_W'(2)); // full window from the third column
				s2_valid <= s1_valid;
				s3_valid <= s2_valid;
				s4_valid <= s3_valid;
				wr_stb   <= s4_valid;
			end
			else if (wr_ack)
			begin
				wr_stb <= 1'b0;
				if (wr_adr == LAST_ADR)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end

			if (take)
			begin
				if (cx == X_LAST)
				begin
					cx       <= '0;
					row_base <= row_base + `ADDR_W'(`IMG_W); // next row of centres
				end
				else
					cx <= cx + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// datapath
	always_ff @(posedge clk)
	begin
		// stage 1, shift the new column into the window
		if (take)
		begin
			a1 <= a2;
			a2 <= a3;
			a3 <= col_top;
			b1 <= b2;
			b2 <= b3;
			b3 <= col_mid;
			c1 <= c2;
			c2 <= c3;
			c3 <= col_bot;
			s1_adr <= row_base + `ADDR_W'(cx) - 1'b1; // centre is one column back
		end

		if (adv)
		begin
			// stage 2, opposing sector pairs
			sec1 <= wsum(a2, a3, b3); // ne
			sec2 <= wsum(b1, c1, c2); // sw
			sec3 <= wsum(a1, a2, a3); // n
			sec4 <= wsum(c1, c2, c3); // s
			sec5 <= wsum(a3, b3, c3); // e
			sec6 <= wsum(a1, b1, c1); // w
			sec7 <= wsum(b1, a1, a2); // nw
			sec8 <= wsum(c2, c3, b3); // se
			s2_adr <= s1_adr;
			s2_pix <= b2;

			// stage 3
			d_ne_sw <= absdiff(sec1, sec2);
			d_n_s   <= absdiff(sec3, sec4);
			d_e_w   <= absdiff(sec5, sec6);
			d_nw_se <= absdiff(sec7, sec8);
			s3_adr  <= s2_adr;
			s3_pix  <= s2_pix;

			// stage 4, decision or passthrough of the centre
			s4_adr <= s3_adr;
			if (show_original)
				s4_dat <= {s3_pix, {(`OUT_W - `PIX_W){1'b0}}};
			else
				s4_dat <= (magnitude > thresh) ? '1 : '0;

			// bus request, held until the ack
			if (s4_valid)
			begin
				wr_adr   <= s4_adr;
				wr_dat_o <= s4_dat;
			end
		end
	end

endmodule

/* logic/edge_detect_top.sv */
/* edge detect top
   fetch, row buffer and sobel core joined by valid/ready streams */

`timescale 1ns/1ns
`include "sobel_defines.svh"

module edge_detect_top
	import sobel_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  pixel_t             pix_threshold,
	input  logic [6:0]         edge_threshold,
	input  logic               show_original,
	// wishbone read port, frame source
	output logic               rd_cyc,
	output logic               rd_stb,
	output logic [`ADDR_W-1:0] rd_adr,
	input  pixel_t             rd_dat_i,
	input  logic               rd_ack,
	// wishbone write port, result sink
	output logic               wr_cyc,
	output logic               wr_stb,
	output logic               wr_we,
	output logic [`ADDR_W-1:0] wr_adr,
	output logic [`OUT_W-1:0]  wr_dat_o,
	input  logic               wr_ack,
	// status
	output logic               busy,
	output logic               done
);

	// fetch -> buffer
	logic   pix_valid;
	pixel_t pix_data;
	logic   pix_ready;

	// buffer -> core
	logic   col_valid;
	pixel_t col_top;
	pixel_t col_mid;
	pixel_t col_bot;
	logic   col_ready;

	pixel_fetch u_fetch
	(
		.clk, .rst_n, .start, .pix_threshold,
		.rd_cyc, .rd_stb, .rd_adr, .rd_dat_i, .rd_ack,
		.pix_valid, .pix_data, .pix_ready
	);

	line_buffer u_buf
	(
		.clk, .rst_n, .start,
		.pix_valid, .pix_data, .pix_ready,
		.col_valid, .col_top, .col_mid, .col_bot, .col_ready
	);

	// core owns busy/done since it sees the last write
	sobel_core u_core
	(
		.clk, .rst_n, .start, .edge_threshold, .show_original,
		.col_valid, .col_top, .col_mid, .col_bot, .col_ready,
		.wr_cyc, .wr_stb, .wr_we, .wr_adr, .wr_dat_o, .wr_ack,
		.busy, .done
	);

endmodule

/* tests/edge_detect_chk.sv */
/* edge detect protocol checks
   wishbone and valid/ready handshake assertions, bound into the top level */

`timescale 1ns/1ns
`include "sobel_defines.svh"

module edge_detect_chk
	import sobel_pkg::*;
(
	input logic               clk,
	input logic               rst_n,
	input logic               rd_cyc,
	input logic               rd_stb,
	input logic [`ADDR_W-1:0] rd_adr,
	input logic               rd_ack,
	input logic               wr_cyc,
	input logic               wr_stb,
	input logic [`ADDR_W-1:0] wr_adr,
	input logic [`OUT_W-1:0]  wr_dat_o,
	input logic               wr_ack,
	input logic               pix_valid,
	input pixel_t             pix_data,
	input logic               pix_ready,
	input logic               col_valid,
	input pixel_t             col_top,
	input pixel_t             col_mid,
	input pixel_t             col_bot,
	input logic               col_ready,
	input logic               done
);

	// one transfer per ack, the bus cycle closes on the following edge
	a_rd_release: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_stb && rd_ack) |=> !(rd_cyc || rd_stb))
		else $error("read cycle still open after ack");
	a_wr_release: assert property (@(posedge clk) disable iff (!rst_n)
		(wr_stb && wr_ack) |=> !(wr_cyc || wr_stb))
		else $error("write cycle still open after ack");

	// pending request keeps its address (and data) until ack
	a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_stb && !rd_ack) |=> (rd_stb && $stable(rd_adr)))
		else $error("read request changed before ack");
	a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(wr_stb && !wr_ack) |=> (wr_stb && $stable(wr_adr) && $stable(wr_dat_o)))
		else $error("write request changed before ack");

	////////////////////////////////////////////////////////////////////////////
	// internal streams, valid and payload held until ready
	a_pix_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(pix_valid && !pix_ready) |=> (pix_valid && $stable(pix_data)))
		else $error("pixel stream dropped before ready");
	a_col_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(col_valid && !col_ready) |=>
		(col_valid && $stable(col_top) && $stable(col_mid) && $stable(col_bot)))
		else $error("column stream dropped before ready");

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else $error("done longer than one cycle"); // single cycle status

endmodule

// ports and internal streams of the top level
bind edge_detect_top edge_detect_chk u_chk
(
	.clk, .rst_n,
	.rd_cyc, .rd_stb, .rd_adr, .rd_ack,
	.wr_cyc, .wr_stb, .wr_adr, .wr_dat_o, .wr_ack,
	.pix_valid, .pix_data, .pix_ready,
	.col_valid, .col_top, .col_mid, .col_bot, .col_ready,
	.done
);

/* tests/tb_edge_detect.sv */
/* edge detect testbench
   wishbone slave models around the DUT, a software model of the edge
   rules and directed frames in both output modes */

`timescale 1ns/1ns
`include "sobel_defines.svh"

module tb_edge_detect
	import sobel_pkg::*;
();

	localparam int NPIX    = `IMG_W * `IMG_H;
	localparam int NWR     = (`IMG_W - 2) * (`IMG_H - 2); // interior centres
	localparam int PIX_MAX = (1 << `PIX_W) - 1;
	localparam int TIMEOUT = 20000; // cycles per wait

	logic               clk = 1'b0;
	logic               rst_n;
	logic               start;
	pixel_t             pix_threshold;
	logic [6:0]         edge_threshold;
	logic               show_original;
	logic               rd_cyc, rd_stb;
	logic [`ADDR_W-1:0] rd_adr;
	pixel_t             rd_dat_i = '0;
	logic               rd_ack = 1'b0;
	logic               wr_cyc, wr_stb, wr_we;
	logic [`ADDR_W-1:0] wr_adr;
	logic [`OUT_W-1:0]  wr_dat_o;
	logic               wr_ack = 1'b0;
	logic               busy, done;

	pixel_t            frame_mem [NPIX]; // source frame
	logic [`OUT_W-1:0] res_mem [NPIX];   // words seen on the write port
	int                res_tag [NPIX];   // run that last wrote each address
	int run_tag, write_cnt, dup_cnt, done_cnt;
	int check_cnt, error_cnt;
	int wait_max; // slave wait states 0..wait_max
	int rd_delay, wr_delay;
	bit hung;

	edge_detect_top UUT
	(
		.clk, .rst_n, .start, .pix_threshold, .edge_threshold, .show_original,
		.rd_cyc, .rd_stb, .rd_adr, .rd_dat_i, .rd_ack,
		.wr_cyc, .wr_stb, .wr_we, .wr_adr, .wr_dat_o, .wr_ack,
		.busy, .done
	);

	always #10 clk = ~clk; // 20 ns

	function automatic int pick_wait();
		return (wait_max == 0) ? 0 : int'($urandom % (wait_max + 1));
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// bus slaves, respond 2 ns after the edge
	always @(posedge clk)
	begin
		#2;
		if (!rst_n || rd_ack)
			rd_ack = 1'b0; // ack lasts one cycle
		else if (rd_cyc && rd_stb)
		begin
			if (rd_delay > 0)
				rd_delay--;
			else
			begin
				rd_dat_i = frame_mem[rd_adr];
				rd_ack   = 1'b1;
				rd_delay = pick_wait();
			end
		end
	end

	always @(posedge clk)
	begin
		#2;
		if (!rst_n || wr_ack)
			wr_ack = 1'b0;
		else if (wr_cyc && wr_stb && wr_we)
		begin
			if (wr_delay > 0)
				wr_delay--;
			else
			begin
				if (res_tag[wr_adr] == run_tag)
					dup_cnt++; // same address twice in one frame
				res_mem[wr_adr] = wr_dat_o;
				res_tag[wr_adr] = run_tag;
				write_cnt++;
				wr_ack   = 1'b1;
				wr_delay = pick_wait();
			end
		end
	end

	always @(negedge clk)
		if (rst_n && done)
			done_cnt++;

	////////////////////////////////////////////////////////////////////////////
	// reference model
	function automatic int bin_pix(input int x, input int y);
		return (frame_mem[y * `IMG_W + x] < pix_threshold) ? 0 : PIX_MAX;
	endfunction

	function automatic logic [`OUT_W-1:0] expect_word(input int x, input int y);
		int p [3][3]; // p[row][col], row above the centre first
		int sec [8];
		int diff [4]; // ne-sw, n-s, e-w, nw-se
		int dx, dy, i;
		int best;
		int mag;
		for (dy = 0; dy < 3; dy++)
			for (dx = 0; dx < 3; dx++)
				p[dy][dx] = bin_pix(x + dx - 1, y + dy - 1);
		if (show_original)
			return `OUT_W'(p[1][1]) << (`OUT_W - `PIX_W);
		// opposing sectors, corner pixel of each weighted twice
		sec[0] = p[0][1] + 2 * p[0][2] + p[1][2]; // ne
		sec[1] = p[1][0] + 2 * p[2][0] + p[2][1]; // sw
		sec[2] = p[0][0] + 2 * p[0][1] + p[0][2]; // n
		sec[3] = p[2][0] + 2 * p[2][1] + p[2][2]; // s
		sec[4] = p[0][2] + 2 * p[1][2] + p[2][2]; // e
		sec[5] = p[0][0] + 2 * p[1][0] + p[2][0]; // w
		sec[6] = p[1][0] + 2 * p[0][0] + p[0][1]; // nw
		sec[7] = p[2][1] + 2 * p[2][2] + p[1][2]; // se
		for (i = 0; i < 4; i++)
			diff[i] = (sec[2*i] > sec[2*i+1]) ? sec[2*i] - sec[2*i+1] : sec[2*i+1] - sec[2*i];
		best = 0;
		for (i = 1; i < 4; i++)
			if (diff[i] >= diff[best])
				best = i; // ties go to the later direction
		mag = diff[best] + (diff[3 - best] >> 3); // right angle partner is 3 - best
		return (mag > int'(edge_threshold) * 32) ? {`OUT_W{1'b1}} : '0;
	endfunction

	task automatic check_value(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		check_cnt++;
		if (expected !== actual)
		begin
			error_cnt++;
			$display("MISMATCH %s: expected %0h, actual %0h", test, expected, actual);
		end
	endtask

	// kind 0 vertical step at x=5 plus a diagonal step, kind 1 noise below 1000
	task automatic load_frame(input int kind);
		int x, y;
		for (y = 0; y < `IMG_H; y++)
			for (x = 0; x < `IMG_W; x++)
				if (kind == 0)
					frame_mem[y*`IMG_W + x] = (x < 5 || x > y + 8) ? pixel_t'(120 + x)
						: pixel_t'(700 + y);
				else
					frame_mem[y*`IMG_W + x] = pixel_t'($urandom % 1000);
	endtask

	task automatic kick_off(input pixel_t pthr, input logic [6:0] ethr, input logic orig);
		@(posedge clk);
		#2;
		pix_threshold  = pthr;
		edge_threshold = ethr;
		show_original  = orig;
		start          = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
	endtask

	task automatic wait_done(input string test);
		int n;
		n = 0;
		while (done !== 1'b1 && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (done !== 1'b1)
		begin
			$display("timeout: no done pulse in %s after %0d cycles", test, TIMEOUT);
			error_cnt++;
			hung = 1'b1;
		end
	endtask

	// one whole frame, then every address against the model
	task automatic run_frame(input string test, input pixel_t pthr, input logic [6:0] ethr,
		input logic orig);
		int base_wr, base_done, base_dup;
		int x, y, a;
		if (hung)
			return;
		run_tag++;
		base_wr   = write_cnt;
		base_done = done_cnt;
		base_dup  = dup_cnt;
		kick_off(pthr, ethr, orig);
		wait_done(test);
		if (hung)
			return;
		repeat (8) @(negedge clk); // room for a stray second done
		check_value({test, " writes"}, NWR, write_cnt - base_wr);
		check_value({test, " done pulses"}, 1, done_cnt - base_done);
		check_value({test, " repeated writes"}, 0, dup_cnt - base_dup);
		for (y = 0; y < `IMG_H; y++)
			for (x = 0; x < `IMG_W; x++)
			begin
				a = y * `IMG_W + x;
				if (x == 0 || y == 0 || x == `IMG_W - 1 || y == `IMG_H - 1)
					check_value({test, " border write"}, 0, res_tag[a] == run_tag);
				else
				begin
					// every interior word must come from this frame
					check_value({test, " missing write"}, 1, res_tag[a] == run_tag);
					check_value(test, expect_word(x, y), res_mem[a]);
				end
			end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	task automatic test_edge_steps();
		wait_max = 1;
		load_frame(0);
		run_frame("edge_steps", 10'd400, 7'd20, 1'b0);
	endtask

	task automatic test_original();
		load_frame(1);
		run_frame("original", 10'd500, 7'd20, 1'b1);
	endtask

	task automatic test_pix_threshold();
		load_frame(1);
		run_frame("all_black", pixel_t'(PIX_MAX), 7'd0, 1'b0); // above every pixel
		run_frame("all_white", 10'd0, 7'd0, 1'b0);
	endtask

	task automatic test_edge_threshold();
		load_frame(0);
		run_frame("edge_thr_0", 10'd400, 7'd0, 1'b0);
		run_frame("edge_thr_127", 10'd400, 7'd127, 1'b0);
	endtask

	task automatic test_back_pressure();
		wait_max = 3;
		load_frame(1);
		run_frame("back_pressure_noise", 10'd500, 7'd16, 1'b0);
		load_frame(0);
		run_frame("back_pressure_steps", 10'd400, 7'd8, 1'b0);
	endtask

	task automatic test_reset_midframe();
		int base, n;
		if (hung)
			return;
		wait_max = 2;
		load_frame(0);
		run_tag++;
		base = write_cnt;
		kick_off(10'd400, 7'd20, 1'b0);
		n = 0;
		while (write_cnt - base < 10 && n < TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (write_cnt - base < 10)
		begin
			$display("timeout: frame made no progress before the mid-frame reset");
			error_cnt++;
			hung = 1'b1;
			return;
		end
		@(posedge clk);
		#2;
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value("reset_midframe busy", 0, busy);
		check_value("reset_midframe rd_cyc", 0, rd_cyc);
		check_value("reset_midframe rd_stb", 0, rd_stb);
		check_value("reset_midframe wr_cyc", 0, wr_cyc);
		check_value("reset_midframe wr_stb", 0, wr_stb);
		@(posedge clk);
		#2;
		rst_n = 1'b1;
		run_frame("after_reset", 10'd400, 7'd20, 1'b0);
	endtask

	initial
	begin
		void'($urandom(32'h0800af95));
		rst_n          = 1'b0;
		start          = 1'b0;
		show_original  = 1'b0;
		pix_threshold  = '0;
		edge_threshold = '0;
		wait_max       = 0;
		repeat (2) @(posedge clk); // two cycles of reset
		#2;
		rst_n = 1'b1;

		test_edge_steps();
		test_original();
		test_pix_threshold();
		test_edge_threshold();
		test_back_pressure();
		test_reset_midframe();

		$display("checks: %0d, errors: %0d", check_cnt, error_cnt);
		if (error_cnt == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+logic
logic/sobel_pkg.sv
logic/pixel_fetch.sv
logic/line_buffer.sv
logic/sobel_core.sv
logic/edge_detect_top.sv
tests/edge_detect_chk.sv
tests/tb_edge_detect.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing --assert
TOP        = tb_edge_detect
FILELIST   = build.f
OBJDIR     = obj_dir
PASS_MSG   = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
